// File: Makefile
# any of these can be set on the make command line
SIM_DIR ?= sim_build
LOG     ?= sim.log
TOP     ?= tb_vi_core
VFLAGS  ?= --binary --timing --assert -j 0

FLIST := vi_core.f
SRCS  := $(shell grep -v '^+' $(FLIST))
BIN   := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	verilator $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(SIM_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)

// File: testbench/tb_clock_gen.sv
// testbench clock and reset

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held for five cycles
	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

// File: testbench/tb_vi_core.sv
// vi_core slice testbench

module tb_vi_core;
	timeunit 1ns;
	timeprecision 100ps;

	import vi_core_pkg::*;

	// transfers per test: first read, loads, alu, bypass, mul, errors, x0
	localparam int N_XFERS = 1 + 24 + 16 + 9 + 10 + 37 + 5;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] model_regs [32];
	logic [31:0] model_retired;
	int          errors;
	int          seed;

	tb_clock_gen u_clock_gen (
		.clk_o		(clk),
		.rst_n_o	(rst_n)
	);

	vi_core u_vi_core (
		.clk_i		(clk),
		.rst_n_i	(rst_n),
		.psel_i		(psel),
		.penable_i	(penable),
		.pwrite_i	(pwrite),
		.paddr_i	(paddr),
		.pwdata_i	(pwdata),
		.prdata_o	(prdata),
		.pready_o	(pready),
		.pslverr_o	(pslverr)
	);

	bind vi_core vi_core_props u_props (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.psel_i		(psel_i),
		.penable_i	(penable_i),
		.pready_i	(pready_o),
		.pslverr_i	(pslverr_o),
		.alu_res_i	(alu_res),
		.mult_last_i	(mult_stage[vi_core_pkg::MULT_STAGES-1])
	);

	// rv32 encodings of the supported subset
	function automatic logic [31:0] encode(input op_e op, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = 7'h00;
		f3 = 3'b000;
		case (op)
			OP_SUB:  f7 = 7'h20;
			OP_AND:  f3 = 3'b111;
			OP_OR:   f3 = 3'b110;
			OP_XOR:  f3 = 3'b100;
			OP_SLT:  f3 = 3'b010;
			OP_MUL:  f7 = 7'h01;
			default: f3 = 3'b000;
		endcase
		if (op == OP_ADDI)
			return {imm, rs1, 3'b000, rd, 7'b0010011};
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] expected_result(input op_e op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_MUL:  return a * b;
			default: return a + b;
		endcase
	endfunction

	// one APB transfer, entered and left 1 ns after a rising edge
	task automatic apb_transfer(input logic wr, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
			output int waits);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waits   = 0;
		@(negedge clk);
		while (!pready) begin
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			input logic exp_err, output int waits);
		logic [31:0] rdata;
		logic        err;
		apb_transfer(1'b1, addr, data, rdata, err, waits);
		assert (err === exp_err) else begin
			errors++;
			$display("Fail at %0t: write to %h gave pslverr %b, expected %b",
				$time, addr, err, exp_err);
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic exp_err,
			output logic [31:0] rdata);
		logic err;
		int   waits;
		apb_transfer(1'b0, addr, 32'd0, rdata, err, waits);
		assert (err === exp_err) else begin
			errors++;
			$display("Fail at %0t: read of %h gave pslverr %b, expected %b",
				$time, addr, err, exp_err);
		end
	endtask

	// issue one instruction and advance the model
	task automatic issue_instr(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [11:0] imm, output int waits);
		logic [31:0] a;
		logic [31:0] b;
		a = model_regs[rs1];
		b = (op == OP_ADDI) ? {{20{imm[11]}}, imm} : model_regs[rs2];
		apb_write(ADDR_INSTR, encode(op, rd, rs1, rs2, imm), 1'b0, waits);
		if (rd != 5'd0)
			model_regs[rd] = expected_result(op, a, b);
		model_retired++;
	endtask

	task automatic check_reg(input logic [4:0] n);
		logic [31:0] rdata;
		apb_read(ADDR_REG_BASE | {1'b0, n, 2'b00}, 1'b0, rdata);
		assert (rdata === model_regs[n]) else begin
			errors++;
			$display("Fail at %0t: x%0d reads %h, expected %h", $time, n, rdata, model_regs[n]);
		end
	endtask

	task automatic check_retired();
		logic [31:0] rdata;
		apb_read(ADDR_RETIRED, 1'b0, rdata);
		assert (rdata === model_retired) else begin
			errors++;
			$display("Fail at %0t: retired count %0d, expected %0d",
				$time, rdata, model_retired);
		end
	endtask

	// x1 forced negative and x2 positive for the signed compare
	task automatic load_registers();
		logic [31:0] rnd;
		logic [11:0] imm;
		int          waits;
		for (int r = 1; r <= 8; r++) begin
			for (int k = 0; k < 3; k++) begin
				rnd = $random(seed);
				imm = rnd[11:0];
				if (r == 1)
					imm[11] = 1'b1;
				if (r == 2)
					imm[11] = 1'b0;
				issue_instr(OP_ADDI, 5'(r), (k == 0) ? 5'd0 : 5'(r), 5'd0, imm, waits);
			end
		end
	endtask

	task automatic test_alu_ops();
		int waits;
		issue_instr(OP_ADD, 5'd10, 5'd1, 5'd2, 12'd0, waits);
		issue_instr(OP_SUB, 5'd11, 5'd3, 5'd4, 12'd0, waits);
		issue_instr(OP_AND, 5'd12, 5'd5, 5'd6, 12'd0, waits);
		issue_instr(OP_OR, 5'd13, 5'd7, 5'd8, 12'd0, waits);
		issue_instr(OP_XOR, 5'd14, 5'd1, 5'd3, 12'd0, waits);
		issue_instr(OP_SLT, 5'd15, 5'd1, 5'd2, 12'd0, waits);
		issue_instr(OP_SLT, 5'd16, 5'd2, 5'd1, 12'd0, waits);
		issue_instr(OP_ADDI, 5'd17, 5'd4, 5'd0, 12'hfff, waits);
		for (int r = 10; r <= 17; r++)
			check_reg(5'(r));
	endtask

	task automatic test_bypass();
		int waits;
		issue_instr(OP_ADD, 5'd20, 5'd1, 5'd2, 12'd0, waits);
		issue_instr(OP_SUB, 5'd21, 5'd20, 5'd3, 12'd0, waits);
		issue_instr(OP_XOR, 5'd22, 5'd21, 5'd20, 12'd0, waits);
		issue_instr(OP_ADDI, 5'd22, 5'd22, 5'd0, 12'h07b, waits);
		issue_instr(OP_OR, 5'd23, 5'd22, 5'd21, 12'd0, waits);
		for (int r = 20; r <= 23; r++)
			check_reg(5'(r));
	endtask

	task automatic test_mul_hazard();
		int waits;
		// negative x1 as operand b puts nonzero bytes in every stage
		issue_instr(OP_MUL, 5'd24, 5'd2, 5'd1, 12'd0, waits);
		issue_instr(OP_ADD, 5'd25, 5'd24, 5'd3, 12'd0, waits);
		assert (waits > 0) else begin
			errors++;
			$display("dependent ADD after MUL was accepted without waiting for the product");
		end
		issue_instr(OP_MUL, 5'd26, 5'd4, 5'd5, 12'd0, waits);
		issue_instr(OP_ADD, 5'd27, 5'd6, 5'd7, 12'd0, waits);
		issue_instr(OP_MUL, 5'd28, 5'd26, 5'd27, 12'd0, waits);
		for (int r = 24; r <= 28; r++)
			check_reg(5'(r));
	endtask

	// nothing may issue, so the model stays as it is
	task automatic test_errors();
		logic [31:0] rdata;
		int          waits;
		apb_write(ADDR_INSTR, 32'hffff_ffff, 1'b1, waits);
		// a legal instruction at the wrong address
		apb_write(ADDR_RETIRED, encode(OP_ADDI, 5'd31, 5'd0, 5'd0, 12'h055), 1'b1, waits);
		apb_read(ADDR_INSTR, 1'b1, rdata);
		apb_read(8'h40, 1'b1, rdata);
		for (int r = 0; r < 32; r++)
			check_reg(5'(r));
		check_retired();
	endtask

	task automatic test_retired_x0();
		int waits;
		check_retired();
		issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'h123, waits);
		issue_instr(OP_ADD, 5'd0, 5'd1, 5'd2, 12'd0, waits);
		check_reg(5'd0);
		check_retired();
	endtask

	initial begin
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = 8'h00;
		pwdata        = 32'd0;
		errors        = 0;
		seed          = 32'h6f0d24e2;
		model_retired = 32'd0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = 32'd0;
		@(posedge rst_n);
		@(posedge clk);
		#1;
		check_retired();
		load_registers();
		test_alu_ops();
		test_bypass();
		test_mul_hazard();
		test_errors();
		test_retired_x0();
		$display("all tests done, errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// about 20 cycles per transfer
	initial begin
		repeat (N_XFERS * 20) @(posedge clk);
		$display("timeout after %0d cycles, the tests did not complete", N_XFERS * 20);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: testbench/vi_core_props.sv
// APB and writeback properties

module vi_core_props (
	input logic             clk_i,
	input logic             rst_n_i,
	input logic             psel_i,
	input logic             penable_i,
	input logic             pready_i,
	input logic             pslverr_i,
	input vi_core_pkg::wb_t alu_res_i,
	input vi_core_pkg::wb_t mult_last_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// ready only ends an access phase, which follows a selected cycle
	ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pready_i |-> (psel_i && penable_i && $past(psel_i)))
		else $error("pready high outside an APB access phase");

	slverr_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pslverr_i |-> pready_i)
		else $error("pslverr high without pready");

	// single write port, the two result sources must not meet
	one_writer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(alu_res_i.valid && mult_last_i.valid))
		else $error("ALU result and multiplier stage 5 valid in the same cycle");

endmodule

// File: verilog/apb_issue.sv
// APB issue sequencer

module apb_issue (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                psel_i,
	input  logic                penable_i,
	input  logic                pwrite_i,
	input  logic [7:0]          paddr_i,
	input  logic [31:0]         pwdata_i,
	input  logic                stall_i,
	input  logic                busy_i,
	input  logic [31:0]         operand_a_i,
	input  logic [31:0]         operand_b_i,
	input  logic [31:0]         dbg_data_i,
	input  logic [31:0]         retired_i,
	output logic [4:0]          rs1_o,
	output logic [4:0]          rs2_o,
	output logic [4:0]          dbg_addr_o,
	output vi_core_pkg::issue_t issue_o,
	output logic [31:0]         prdata_o,
	output logic                pready_o,
	output logic                pslverr_o
);

	import vi_core_pkg::*;

	apb_state_e  state_q;
	apb_state_e  state_d;
	op_e         dec_op;
	logic [6:0]  funct7;
	logic [2:0]  funct3;
	logic [31:0] imm;
	logic        sel_instr;
	logic        sel_retired;
	logic        sel_reg;
	logic        access;
	logic        err;
	logic        done;

	assign funct7 = pwdata_i[31:25];
	assign funct3 = pwdata_i[14:12];
	assign imm    = {{20{pwdata_i[31]}}, pwdata_i[31:20]};
	assign rs1_o  = pwdata_i[19:15];
	assign rs2_o  = pwdata_i[24:20];

	// rv32 decode
	always_comb begin
		dec_op = OP_ILLEGAL;
		case (pwdata_i[6:0])
			OPC_OP: begin
				case ({funct7, funct3})
					{F7_BASE, F3_ADD}:   dec_op = OP_ADD;
					{F7_ALT, F3_ADD}:    dec_op = OP_SUB;
					{F7_BASE, F3_AND}:   dec_op = OP_AND;
					{F7_BASE, F3_OR}:    dec_op = OP_OR;
					{F7_BASE, F3_XOR}:   dec_op = OP_XOR;
					{F7_BASE, F3_SLT}:   dec_op = OP_SLT;
					{F7_MULDIV, F3_ADD}: dec_op = OP_MUL;
					default:             dec_op = OP_ILLEGAL;
				endcase
			end
			OPC_OP_IMM: begin
				if (funct3 == F3_ADD)
					dec_op = OP_ADDI;
			end
			default: dec_op = OP_ILLEGAL;
		endcase
	end

	// address decode, registers live word aligned at 0x80..0xfc
	assign sel_instr   = (paddr_i == ADDR_INSTR);
	assign sel_retired = (paddr_i == ADDR_RETIRED);
	assign sel_reg     = ((paddr_i & 8'h83) == ADDR_REG_BASE);
	assign dbg_addr_o  = paddr_i[6:2];

	always_comb begin
		err  = 1'b1;
		done = 1'b1;
		if (pwrite_i) begin
			if (sel_instr && dec_op != OP_ILLEGAL) begin
				err  = 1'b0;
				done = !stall_i;
			end
		end else if (sel_retired || sel_reg) begin
			err  = 1'b0;
			done = !busy_i;
		end
	end

	assign access    = psel_i && penable_i && (state_q != ST_IDLE);
	assign pready_o  = access && done;
	assign pslverr_o = pready_o && err;
	assign prdata_o  = sel_retired ? retired_i : (sel_reg ? dbg_data_i : 32'd0);

	// issue fires on the completing edge only
	always_comb begin
		issue_o.valid     = pready_o && pwrite_i && !err;
		issue_o.op        = (psel_i && pwrite_i && sel_instr) ? dec_op : OP_ILLEGAL;
		issue_o.rd        = pwdata_i[11:7];
		issue_o.operand_a = operand_a_i;
		issue_o.operand_b = (dec_op == OP_ADDI) ? imm : operand_b_i;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (psel_i && !penable_i)
					state_d = ST_ACCESS;
			end
			ST_ACCESS, ST_WAIT: begin
				if (pready_o || !psel_i)
					state_d = ST_IDLE;
				else
					state_d = ST_WAIT;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

endmodule

// File: verilog/bypass_ctrl.sv
// operand bypass and hazard control

module bypass_ctrl (
	input  logic [4:0]       rs1_i,
	input  logic [4:0]       rs2_i,
	input  vi_core_pkg::op_e op_i,
	input  logic             req_i,
	input  logic [31:0]      rf_a_i,
	input  logic [31:0]      rf_b_i,
	input  vi_core_pkg::wb_t alu_res_i,
	input  vi_core_pkg::wb_t mult_stage_i [vi_core_pkg::MULT_STAGES],
	output logic [31:0]      operand_a_o,
	output logic [31:0]      operand_b_o,
	output logic             stall_o,
	output logic             busy_o
);

	import vi_core_pkg::*;

	logic hit_a;
	logic hit_b;
	logic mult_busy;
	logic uses_rs2;
	logic waiting;

	// alu first, then the last multiplier stage, then the register file
	function automatic logic [31:0] resolve(input logic [4:0] rs, input logic [31:0] rf_data,
			input wb_t alu, input wb_t mult_last);
		logic [31:0] data;
		if (rs == 5'd0)
			data = 32'd0;
		else if (alu.valid && alu.rd == rs)
			data = alu.data;
		else if (mult_last.valid && mult_last.rd == rs)
			data = mult_last.data;
		else
			data = rf_data;
		return data;
	endfunction

	assign operand_a_o = resolve(rs1_i, rf_a_i, alu_res_i, mult_stage_i[MULT_STAGES-1]);
	assign operand_b_o = resolve(rs2_i, rf_b_i, alu_res_i, mult_stage_i[MULT_STAGES-1]);

	// products still in flight cannot be forwarded
	always_comb begin
		hit_a     = 1'b0;
		hit_b     = 1'b0;
		mult_busy = 1'b0;
		for (int i = 0; i < MULT_STAGES; i++) begin
			mult_busy = mult_busy | mult_stage_i[i].valid;
			if (i < MULT_STAGES - 1 && mult_stage_i[i].valid) begin
				if (mult_stage_i[i].rd == rs1_i)
					hit_a = 1'b1;
				if (mult_stage_i[i].rd == rs2_i)
					hit_b = 1'b1;
			end
		end
	end

	// addi carries immediate bits in the rs2 field
	assign uses_rs2 = (op_i != OP_ADDI);
	assign waiting  = req_i && (op_i != OP_ILLEGAL);

	assign stall_o = waiting && ((hit_a && rs1_i != 5'd0)
		|| (uses_rs2 && hit_b && rs2_i != 5'd0)
		|| (op_i != OP_MUL && mult_stage_i[MULT_STAGES-2].valid));

	assign busy_o = alu_res_i.valid || mult_busy;

endmodule

// File: verilog/exe_stage.sv
// execute latch and integer ALU

module exe_stage (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  vi_core_pkg::issue_t issue_i,
	output vi_core_pkg::wb_t    alu_res_o
);

	import vi_core_pkg::*;

	logic        take;
	logic        valid_q;
	op_e         op_q;
	logic [4:0]  rd_q;
	logic [31:0] a_q;
	logic [31:0] b_q;
	logic [31:0] result;

	// MUL goes to the multiplier only
	assign take = issue_i.valid && (issue_i.op != OP_MUL);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			valid_q <= 1'b0;
		else
			valid_q <= take;
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			op_q <= issue_i.op;
			rd_q <= issue_i.rd;
			a_q  <= issue_i.operand_a;
			b_q  <= issue_i.operand_b;
		end
	end

	always_comb begin
		case (op_q)
			OP_ADD, OP_ADDI: result = a_q + b_q;
			OP_SUB:          result = a_q - b_q;
			OP_AND:          result = a_q & b_q;
			OP_OR:           result = a_q | b_q;
			OP_XOR:          result = a_q ^ b_q;
			OP_SLT:          result = {31'd0, $signed(a_q) < $signed(b_q)};
			default:         result = 32'd0;
		endcase
	end

	assign alu_res_o.valid = valid_q;
	assign alu_res_o.rd    = rd_q;
	assign alu_res_o.data  = result;

endmodule

// File: verilog/int_registers.sv
// integer register file

module int_registers (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic [4:0]       rs1_i,
	input  logic [4:0]       rs2_i,
	input  logic [4:0]       dbg_addr_i,
	input  vi_core_pkg::wb_t wr_i,
	output logic [31:0]      rd_a_o,
	output logic [31:0]      rd_b_o,
	output logic [31:0]      dbg_data_o
);

	logic [31:0] regs [32];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (wr_i.valid && wr_i.rd != 5'd0) begin
			// x0 stays zero
			regs[wr_i.rd] <= wr_i.data;
		end
	end

	assign rd_a_o     = regs[rs1_i];
	assign rd_b_o     = regs[rs2_i];
	assign dbg_data_o = regs[dbg_addr_i];

endmodule

// File: verilog/mult_pipe.sv
// five stage multiplier

module mult_pipe (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  vi_core_pkg::issue_t issue_i,
	output vi_core_pkg::wb_t    stage_o [vi_core_pkg::MULT_STAGES]
);

	import vi_core_pkg::*;

	logic        valid_q [MULT_STAGES];
	logic [4:0]  rd_q    [MULT_STAGES];
	logic [31:0] acc_q   [MULT_STAGES];
	// operands only needed until the last byte is folded in
	logic [31:0] a_q     [MULT_STAGES-2];
	logic [31:0] b_q     [MULT_STAGES-2];

	// one byte of b per stage, low 32 bits kept
	function automatic logic [31:0] partial(input logic [31:0] a, input logic [31:0] b,
			input int k);
		logic [31:0] b_byte;
		b_byte = {24'd0, b[8*k +: 8]};
		return (a * b_byte) << (8 * k);
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < MULT_STAGES; i++)
				valid_q[i] <= 1'b0;
		end else begin
			valid_q[0] <= issue_i.valid && (issue_i.op == OP_MUL);
			for (int i = 1; i < MULT_STAGES; i++)
				valid_q[i] <= valid_q[i-1];
		end
	end

	always_ff @(posedge clk_i) begin
		rd_q[0]  <= issue_i.rd;
		a_q[0]   <= issue_i.operand_a;
		b_q[0]   <= issue_i.operand_b;
		acc_q[0] <= partial(issue_i.operand_a, issue_i.operand_b, 0);
		for (int i = 1; i < MULT_STAGES; i++)
			rd_q[i] <= rd_q[i-1];
		for (int i = 1; i < MULT_STAGES - 2; i++) begin
			a_q[i] <= a_q[i-1];
			b_q[i] <= b_q[i-1];
		end
		for (int i = 1; i < MULT_STAGES - 1; i++)
			acc_q[i] <= acc_q[i-1] + partial(a_q[i-1], b_q[i-1], i);
		// last stage just registers the finished product
		acc_q[MULT_STAGES-1] <= acc_q[MULT_STAGES-2];
	end

	always_comb begin
		for (int i = 0; i < MULT_STAGES; i++) begin
			stage_o[i].valid = valid_q[i];
			stage_o[i].rd    = rd_q[i];
			stage_o[i].data  = acc_q[i];
		end
	end

endmodule

// File: verilog/vi_core.sv
// vi_core execute slice top

module vi_core (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o
);

	import vi_core_pkg::*;

	// issue side
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  dbg_addr;
	logic [31:0] rf_a;
	logic [31:0] rf_b;
	logic [31:0] dbg_data;
	logic [31:0] operand_a;
	logic [31:0] operand_b;
	logic        stall;
	logic        busy;
	issue_t      issue;

	// result side
	wb_t         alu_res;
	wb_t         mult_stage [MULT_STAGES];
	wb_t         wr;
	logic [31:0] retired;

	apb_issue apb_issue (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.psel_i		(psel_i),
		.penable_i	(penable_i),
		.pwrite_i	(pwrite_i),
		.paddr_i	(paddr_i),
		.pwdata_i	(pwdata_i),
		.stall_i	(stall),
		.busy_i		(busy),
		.operand_a_i	(operand_a),
		.operand_b_i	(operand_b),
		.dbg_data_i	(dbg_data),
		.retired_i	(retired),
		.rs1_o		(rs1),
		.rs2_o		(rs2),
		.dbg_addr_o	(dbg_addr),
		.issue_o	(issue),
		.prdata_o	(prdata_o),
		.pready_o	(pready_o),
		.pslverr_o	(pslverr_o)
	);

	// op is OP_ILLEGAL unless an instruction write is pending
	bypass_ctrl bypass_ctrl (
		.rs1_i		(rs1),
		.rs2_i		(rs2),
		.op_i		(issue.op),
		.req_i		(psel_i),
		.rf_a_i		(rf_a),
		.rf_b_i		(rf_b),
		.alu_res_i	(alu_res),
		.mult_stage_i	(mult_stage),
		.operand_a_o	(operand_a),
		.operand_b_o	(operand_b),
		.stall_o	(stall),
		.busy_o		(busy)
	);

	int_registers int_registers (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.rs1_i		(rs1),
		.rs2_i		(rs2),
		.dbg_addr_i	(dbg_addr),
		.wr_i		(wr),
		.rd_a_o		(rf_a),
		.rd_b_o		(rf_b),
		.dbg_data_o	(dbg_data)
	);

	exe_stage exe_stage (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.issue_i	(issue),
		.alu_res_o	(alu_res)
	);

	mult_pipe mult_pipe (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.issue_i	(issue),
		.stage_o	(mult_stage)
	);

	wb_retire wb_retire (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.alu_res_i	(alu_res),
		.mult_res_i	(mult_stage[MULT_STAGES-1]),
		.wr_o		(wr),
		.retired_o	(retired)
	);

endmodule

// File: verilog/vi_core_pkg.sv
// vi_core shared definitions

package vi_core_pkg;

	// operations handled by the slice
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_ADDI,
		OP_MUL,
		OP_ILLEGAL
	} op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_WAIT
	} apb_state_e;

	// decoded instruction with resolved operands
	typedef struct packed {
		logic        valid;
		op_e         op;
		logic [4:0]  rd;
		logic [31:0] operand_a;
		logic [31:0] operand_b;
	} issue_t;

	// result heading for the register file
	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_t;

	// apb address map
	localparam logic [7:0] ADDR_INSTR    = 8'h00;
	localparam logic [7:0] ADDR_RETIRED  = 8'h04;
	localparam logic [7:0] ADDR_REG_BASE = 8'h80;

	localparam int MULT_STAGES = 5;

	// rv32 encoding fields
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000;
	localparam logic [6:0] F7_MULDIV  = 7'b0000001;
	localparam logic [2:0] F3_ADD     = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

endpackage

// File: verilog/wb_retire.sv
// writeback select and retire counter

module wb_retire (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  vi_core_pkg::wb_t alu_res_i,
	input  vi_core_pkg::wb_t mult_res_i,
	output vi_core_pkg::wb_t wr_o,
	output logic [31:0]      retired_o
);

	logic [31:0] count_q;

	// stall logic keeps the two sources apart
	assign wr_o = alu_res_i.valid ? alu_res_i : mult_res_i;

	// writes to x0 still retire
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			count_q <= 32'd0;
		else if (wr_o.valid)
			count_q <= count_q + 32'd1;
	end

	assign retired_o = count_q;

endmodule

// File: vi_core.f
verilog/vi_core_pkg.sv
verilog/apb_issue.sv
verilog/bypass_ctrl.sv
verilog/int_registers.sv
verilog/exe_stage.sv
verilog/mult_pipe.sv
verilog/wb_retire.sv
verilog/vi_core.sv
testbench/tb_clock_gen.sv
testbench/vi_core_props.sv
testbench/tb_vi_core.sv
